/* include/dacfifo_params.svh */
// DAC FIFO write path parameters

`ifndef DACFIFO_PARAMS_SVH
`define DACFIFO_PARAMS_SVH

// ********************
// data path widths
// ********************

`define DACFIFO_DMA_DATA_WIDTH 32
`define DACFIFO_AVL_DATA_WIDTH 128
`define DACFIFO_MEM_RATIO 4
`define DACFIFO_LANE_SEL_WIDTH 2
`define DACFIFO_DMA_BYTES 4
`define DACFIFO_AVL_BYTES 16

// word buffer depth is 2**addr_width
`define DACFIFO_BUF_ADDR_WIDTH 4
`define DACFIFO_BUF_THRESHOLD_HI 14

// external memory window, word addresses, limit inclusive
`define DACFIFO_AVL_ADDR_WIDTH 25
`define DACFIFO_DDR_BASE_ADDRESS 16
`define DACFIFO_DDR_ADDRESS_LIMIT 63

`endif

/* src/dacfifo_pkg.sv */
// DAC FIFO shared types

`include "dacfifo_params.svh"

package dacfifo_pkg;

  // ********************
  // avalon word
  // ********************

  // one avalon word, seen either as dma lanes or as a flat vector
  // lane 0 sits in the least significant bits
  typedef union packed {
    logic [`DACFIFO_MEM_RATIO-1:0][`DACFIFO_DMA_DATA_WIDTH-1:0] lane;
    logic [`DACFIFO_AVL_DATA_WIDTH-1:0]                         flat;
  } avl_word_u;

  // ********************
  // dma side
  // ********************

  // one accepted dma beat
  typedef struct packed {
    logic [`DACFIFO_DMA_DATA_WIDTH-1:0] data;
    logic                               last;
  } dma_beat_t;

  // ********************
  // buffer entry
  // ********************

  // packed word as held in the word buffer
  // lane_count is the highest filled lane, valid only with last set
  typedef struct packed {
    avl_word_u                          word;
    logic                               last;
    logic [`DACFIFO_LANE_SEL_WIDTH-1:0] lane_count;
  } buf_word_t;

endpackage

/* src/dma_beat_packer.sv */
// DMA beat packer

`include "dacfifo_params.svh"

module dma_beat_packer (
  input  logic                   avl_clk,
  input  logic                   avl_reset,
  input  logic                   dma_xfer_req,
  input  logic                   beat_valid,
  input  dacfifo_pkg::dma_beat_t beat,
  output logic                   push,
  output dacfifo_pkg::buf_word_t push_word
);

  localparam int LANE_SEL_W = `DACFIFO_LANE_SEL_WIDTH;
  localparam int FILL_W = `DACFIFO_AVL_DATA_WIDTH - `DACFIFO_DMA_DATA_WIDTH;
  localparam logic [LANE_SEL_W-1:0] LAST_LANE = LANE_SEL_W'(`DACFIFO_MEM_RATIO - 1);

  logic [LANE_SEL_W-1:0] lane_idx;
  logic                  word_end;

  // a word closes on the top lane or on the final beat of a transfer
  assign word_end = beat.last || (lane_idx == LAST_LANE);

  // ********************
  // lane tracking
  // ********************

  always_ff @(posedge avl_clk) begin
    if (avl_reset || !dma_xfer_req) begin
      lane_idx <= '0;
      push <= 1'b0;
    end else begin
      push <= 1'b0;
      if (beat_valid) begin
        if (word_end) begin
          push <= 1'b1;
          lane_idx <= '0;
        end else begin
          lane_idx <= lane_idx + 1'b1;
        end
      end
    end
  end

  // ********************
  // word assembly
  // ********************

  // the buffer samples push_word on the edge where push is high, so a
  // beat landing in lane 0 on that same edge does not disturb it
  always_ff @(posedge avl_clk) begin
    if (beat_valid) begin
      if (lane_idx == '0) begin
        // start a fresh word, unused upper lanes read as zero
        push_word.word.flat <= {{FILL_W{1'b0}}, beat.data};
      end else begin
        push_word.word.lane[lane_idx] <= beat.data;
      end
      push_word.last <= beat.last;
      push_word.lane_count <= lane_idx;
    end
  end

endmodule

/* src/word_buffer.sv */
// Packed word buffer

`include "dacfifo_params.svh"

module word_buffer (
  input  logic                   avl_clk,
  input  logic                   avl_reset,
  input  logic                   dma_xfer_req,
  input  logic                   dma_valid,
  output logic                   dma_ready_out,
  output logic                   beat_valid,
  input  logic                   push,
  input  dacfifo_pkg::buf_word_t push_word,
  output dacfifo_pkg::buf_word_t pop_word,
  output logic                   pop_valid,
  input  logic                   pop_ready
);

  localparam int ADDR_W = `DACFIFO_BUF_ADDR_WIDTH;
  localparam int DEPTH = 1 << ADDR_W;
  localparam logic [ADDR_W:0] FULL_LEVEL = (ADDR_W + 1)'(DEPTH);
  localparam logic [ADDR_W:0] THRESHOLD_HI = (ADDR_W + 1)'(`DACFIFO_BUF_THRESHOLD_HI);

  dacfifo_pkg::buf_word_t mem [DEPTH];

  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   level;
  logic              pop;

  // accepted dma beat
  assign beat_valid = dma_valid && dma_ready_out && dma_xfer_req;

  assign pop = pop_valid && pop_ready;
  assign pop_valid = (level != '0);
  assign pop_word = mem[rd_ptr];

  // ********************
  // storage
  // ********************

  always_ff @(posedge avl_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // ********************
  // pointers and level
  // ********************

  // the buffer empties whenever the transfer request is dropped
  always_ff @(posedge avl_clk) begin
    if (avl_reset || !dma_xfer_req) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: level <= level + 1'b1;
        2'b01: level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // dma flow control, follows the level one cycle late
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      dma_ready_out <= 1'b0;
    end else begin
      dma_ready_out <= dma_xfer_req && (level < THRESHOLD_HI);
    end
  end

  // the threshold must leave room for beats still in the packer
  a_no_push_when_full : assert property (
    @(posedge avl_clk) disable iff (avl_reset || !dma_xfer_req)
    push |-> (level != FULL_LEVEL)
  ) else $error("word buffer pushed while full");

endmodule

/* src/avl_write_master.sv */
// Avalon write master

`include "dacfifo_params.svh"

module avl_write_master (
  input  logic                                  avl_clk,
  input  logic                                  avl_reset,
  input  logic                                  dma_xfer_req,
  input  dacfifo_pkg::buf_word_t                pop_word,
  input  logic                                  pop_valid,
  output logic                                  pop_ready,
  input  logic                                  avl_ready,
  output logic                                  avl_write,
  output logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]    avl_address,
  output logic [`DACFIFO_AVL_DATA_WIDTH-1:0]    avl_data,
  output logic [`DACFIFO_AVL_BYTES-1:0]         avl_byteenable,
  output logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]    avl_last_address,
  output logic [`DACFIFO_AVL_BYTES-1:0]         avl_last_byteenable,
  output logic                                  avl_xfer_req
);

  localparam int ADDR_W = `DACFIFO_AVL_ADDR_WIDTH;
  localparam int LANES = `DACFIFO_MEM_RATIO;
  localparam int LANE_BYTES = `DACFIFO_DMA_BYTES;
  localparam logic [ADDR_W-1:0] BASE_ADDR = ADDR_W'(`DACFIFO_DDR_BASE_ADDRESS);
  localparam logic [ADDR_W-1:0] LIMIT_ADDR = ADDR_W'(`DACFIFO_DDR_ADDRESS_LIMIT);

  logic                         xfer_req_d;
  logic                         xfer_start;
  logic                         write_active;
  logic                         cur_last;
  logic                         last_done;
  logic                         word_take;
  logic                         write_done;
  logic [ADDR_W-1:0]            next_address;
  logic [`DACFIFO_AVL_BYTES-1:0] be_next;

  // one write outstanding at a time
  assign pop_ready = write_active && !avl_write;
  assign word_take = pop_valid && pop_ready;
  assign write_done = avl_write && avl_ready;
  assign xfer_start = dma_xfer_req && !xfer_req_d;

  // wrap inside the memory window
  assign next_address = (avl_address == LIMIT_ADDR) ? BASE_ADDR : avl_address + 1'b1;

  // byteenable per lane, partial only on the last word
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (!pop_word.last || (i <= int'(pop_word.lane_count))) begin
        be_next[i*LANE_BYTES +: LANE_BYTES] = {LANE_BYTES{1'b1}};
      end else begin
        be_next[i*LANE_BYTES +: LANE_BYTES] = {LANE_BYTES{1'b0}};
      end
    end
  end

  // ********************
  // write control
  // ********************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      xfer_req_d <= 1'b0;
      write_active <= 1'b0;
      avl_write <= 1'b0;
      cur_last <= 1'b0;
      last_done <= 1'b0;
      avl_xfer_req <= 1'b0;
      avl_address <= BASE_ADDR;
    end else begin
      xfer_req_d <= dma_xfer_req;
      last_done <= 1'b0;
      // new session
      if (xfer_start) begin
        write_active <= 1'b1;
        avl_xfer_req <= 1'b0;
        avl_address <= BASE_ADDR;
      end
      if (word_take) begin
        avl_write <= 1'b1;
        cur_last <= pop_word.last;
      end else if (write_done) begin
        avl_write <= 1'b0;
        if (cur_last) begin
          // address stays on the final write for the capture below
          write_active <= 1'b0;
          last_done <= 1'b1;
        end else begin
          avl_address <= next_address;
        end
      end
      if (last_done) begin
        avl_xfer_req <= 1'b1;
      end
    end
  end

  // ********************
  // payload and capture
  // ********************

  always_ff @(posedge avl_clk) begin
    if (word_take) begin
      avl_data <= pop_word.word.flat;
      avl_byteenable <= be_next;
    end
    // last write details for the reader
    if (last_done) begin
      avl_last_address <= avl_address;
      avl_last_byteenable <= avl_byteenable;
    end
  end

  // a stalled write keeps its command steady until the memory takes it
  a_stall_stable : assert property (
    @(posedge avl_clk) disable iff (avl_reset)
    (avl_write && !avl_ready) |=>
      (avl_write && $stable(avl_address) && $stable(avl_data) && $stable(avl_byteenable))
  ) else $error("avalon write changed while stalled");

endmodule

/* src/avl_dacfifo_wr.sv */
// DAC FIFO write path top

`include "dacfifo_params.svh"

module avl_dacfifo_wr (
  input  logic                                  avl_clk,
  input  logic                                  avl_reset,
  input  logic [`DACFIFO_DMA_DATA_WIDTH-1:0]    dma_data,
  input  logic                                  dma_valid,
  input  logic                                  dma_xfer_req,
  input  logic                                  dma_xfer_last,
  output logic                                  dma_ready_out,
  output logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]    avl_address,
  output logic [`DACFIFO_AVL_DATA_WIDTH-1:0]    avl_data,
  output logic [`DACFIFO_AVL_BYTES-1:0]         avl_byteenable,
  output logic                                  avl_write,
  input  logic                                  avl_ready,
  output logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]    avl_last_address,
  output logic [`DACFIFO_AVL_BYTES-1:0]         avl_last_byteenable,
  output logic                                  avl_xfer_req
);

  dacfifo_pkg::dma_beat_t beat;
  dacfifo_pkg::buf_word_t push_word;
  dacfifo_pkg::buf_word_t pop_word;
  logic                   beat_valid;
  logic                   push;
  logic                   pop_valid;
  logic                   pop_ready;

  assign beat = '{data: dma_data, last: dma_xfer_last};

  // ********************
  // dma side
  // ********************

  dma_beat_packer u_dma_beat_packer (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .dma_xfer_req (dma_xfer_req),
    .beat_valid   (beat_valid),
    .beat         (beat),
    .push         (push),
    .push_word    (push_word)
  );

  word_buffer u_word_buffer (
    .avl_clk       (avl_clk),
    .avl_reset     (avl_reset),
    .dma_xfer_req  (dma_xfer_req),
    .dma_valid     (dma_valid),
    .dma_ready_out (dma_ready_out),
    .beat_valid    (beat_valid),
    .push          (push),
    .push_word     (push_word),
    .pop_word      (pop_word),
    .pop_valid     (pop_valid),
    .pop_ready     (pop_ready)
  );

  // ********************
  // memory side
  // ********************

  avl_write_master u_avl_write_master (
    .avl_clk             (avl_clk),
    .avl_reset           (avl_reset),
    .dma_xfer_req        (dma_xfer_req),
    .pop_word            (pop_word),
    .pop_valid           (pop_valid),
    .pop_ready           (pop_ready),
    .avl_ready           (avl_ready),
    .avl_write           (avl_write),
    .avl_address         (avl_address),
    .avl_data            (avl_data),
    .avl_byteenable      (avl_byteenable),
    .avl_last_address    (avl_last_address),
    .avl_last_byteenable (avl_last_byteenable),
    .avl_xfer_req        (avl_xfer_req)
  );

endmodule

/* verification/tb_avl_dacfifo_wr.sv */
// DAC FIFO write path testbench

`include "dacfifo_params.svh"

module tb_avl_dacfifo_wr;

  localparam int DW = `DACFIFO_DMA_DATA_WIDTH;
  localparam int AVL_DW = `DACFIFO_AVL_DATA_WIDTH;
  localparam int AW = `DACFIFO_AVL_ADDR_WIDTH;
  localparam int BW = `DACFIFO_AVL_BYTES;
  localparam int LANES = `DACFIFO_MEM_RATIO;
  localparam int BASE = `DACFIFO_DDR_BASE_ADDRESS;
  localparam int WINDOW = `DACFIFO_DDR_ADDRESS_LIMIT - `DACFIFO_DDR_BASE_ADDRESS + 1;
  localparam int TOTAL_BEATS = 32 + 9 + 14 + 7 + 120 + 240 + 22 + 17;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 40 + 2000;

  typedef struct packed {
    logic [AW-1:0]     address;
    logic [AVL_DW-1:0] data;
    logic [BW-1:0]     byteenable;
  } avl_write_t;

  logic              avl_clk;
  logic              avl_reset;
  logic [DW-1:0]     dma_data;
  logic              dma_valid;
  logic              dma_xfer_req;
  logic              dma_xfer_last;
  logic              dma_ready_out;
  logic [AW-1:0]     avl_address;
  logic [AVL_DW-1:0] avl_data;
  logic [BW-1:0]     avl_byteenable;
  logic              avl_write;
  logic              avl_ready;
  logic [AW-1:0]     avl_last_address;
  logic [BW-1:0]     avl_last_byteenable;
  logic              avl_xfer_req;

  logic [DW-1:0] beat_list [$];
  integer        seed = 10676;
  int            n_words = 0;
  int            wr_count = 0;
  int            error_count = 0;
  int            test_count = 0;
  int            fail_count = 0;
  int            ready_mode = 0;
  int            cycle_count = 0;
  int            stall_end = 0;
  int            ready_low_count = 0;
  logic          stalled;
  avl_write_t    held;

  avl_dacfifo_wr u_avl_dacfifo_wr (
    .avl_clk             (avl_clk),
    .avl_reset           (avl_reset),
    .dma_data            (dma_data),
    .dma_valid           (dma_valid),
    .dma_xfer_req        (dma_xfer_req),
    .dma_xfer_last       (dma_xfer_last),
    .dma_ready_out       (dma_ready_out),
    .avl_address         (avl_address),
    .avl_data            (avl_data),
    .avl_byteenable      (avl_byteenable),
    .avl_write           (avl_write),
    .avl_ready           (avl_ready),
    .avl_last_address    (avl_last_address),
    .avl_last_byteenable (avl_last_byteenable),
    .avl_xfer_req        (avl_xfer_req)
  );

  initial begin
    avl_clk = 1'b0;
    forever begin
      #2 avl_clk = ~avl_clk;
    end
  end

  // ********************
  // reference model
  // ********************

  // word idx holds beats 4*idx to 4*idx+3
  // the last word enables only its filled lanes
  function automatic avl_write_t expected_word(input int idx);
    avl_write_t w;
    int lane;
    int beat_idx;
    int lanes_used;
    w = '0;
    lanes_used = LANES;
    if (idx == (beat_list.size() - 1) / LANES) begin
      lanes_used = beat_list.size() - idx * LANES;
    end
    for (lane = 0; lane < LANES; lane++) begin
      beat_idx = idx * LANES + lane;
      if (beat_idx < beat_list.size()) begin
        w.data[lane*DW +: DW] = beat_list[beat_idx];
      end
      if (lane < lanes_used) begin
        w.byteenable[lane*`DACFIFO_DMA_BYTES +: `DACFIFO_DMA_BYTES] = '1;
      end
    end
    w.address = AW'(BASE + idx % WINDOW);
    return w;
  endfunction

  task automatic report_mismatch(input string name, input string where,
                                 input logic [AVL_DW-1:0] got,
                                 input logic [AVL_DW-1:0] expected);
    error_count++;
    $display("MISMATCH %s %s: got 0x%0h, expected 0x%0h", name, where, got, expected);
  endtask

  task automatic check_write(input int idx);
    avl_write_t exp;
    logic [AVL_DW-1:0] mask;
    string where;
    int b;
    exp = expected_word(idx);
    where = $sformatf("at word %0d", idx);
    // disabled byte lanes carry no data
    for (b = 0; b < BW; b++) begin
      mask[b*8 +: 8] = exp.byteenable[b] ? 8'hff : 8'h00;
    end
    if (idx >= n_words) begin
      error_count++;
      $display("write %0d was issued after the last word of the transfer", idx);
    end
    if (avl_xfer_req !== 1'b0) begin
      report_mismatch("avl_xfer_req", where, AVL_DW'(avl_xfer_req), AVL_DW'(1'b0));
    end
    if (avl_address !== exp.address) begin
      report_mismatch("avl_address", where, AVL_DW'(avl_address), AVL_DW'(exp.address));
    end
    if (avl_byteenable !== exp.byteenable) begin
      report_mismatch("avl_byteenable", where, AVL_DW'(avl_byteenable),
                      AVL_DW'(exp.byteenable));
    end
    if ((avl_data & mask) !== (exp.data & mask)) begin
      report_mismatch("avl_data", where, avl_data & mask, exp.data & mask);
    end
  endtask

  // ********************
  // memory side
  // ********************

  // avl_ready follows the test mode and is forced low inside a stall window
  initial begin
    logic [31:0] rnd;
    avl_ready <= 1'b0;
    forever begin
      @(posedge avl_clk);
      cycle_count = cycle_count + 1;
      if (cycle_count < stall_end) begin
        avl_ready <= 1'b0;
      end else if (ready_mode == 1) begin
        rnd = $random(seed);
        avl_ready <= (rnd[1:0] != 2'b00);
      end else begin
        avl_ready <= 1'b1;
      end
    end
  end

  // accepted writes are compared mid-cycle where everything is settled
  initial begin
    stalled = 1'b0;
    forever begin
      @(negedge avl_clk);
      if (stalled) begin
        if (avl_write !== 1'b1) begin
          report_mismatch("stalled avl_write", $sformatf("at word %0d", wr_count),
                          AVL_DW'(avl_write), AVL_DW'(1'b1));
        end
        if (avl_address !== held.address) begin
          report_mismatch("stalled avl_address", $sformatf("at word %0d", wr_count),
                          AVL_DW'(avl_address), AVL_DW'(held.address));
        end
        if (avl_data !== held.data) begin
          report_mismatch("stalled avl_data", $sformatf("at word %0d", wr_count),
                          avl_data, held.data);
        end
        if (avl_byteenable !== held.byteenable) begin
          report_mismatch("stalled avl_byteenable", $sformatf("at word %0d", wr_count),
                          AVL_DW'(avl_byteenable), AVL_DW'(held.byteenable));
        end
      end
      if (avl_write === 1'b1 && avl_ready === 1'b1) begin
        check_write(wr_count);
        wr_count++;
      end
      stalled = (avl_write === 1'b1) && (avl_ready === 1'b0);
      held = '{address: avl_address, data: avl_data, byteenable: avl_byteenable};
      if (cycle_count < stall_end && stalled && dma_xfer_req && !dma_ready_out) begin
        ready_low_count++;
      end
    end
  end

  // ********************
  // dma side
  // ********************

  task automatic drive_beats(input int n_beats);
    int idx;
    idx = 0;
    @(posedge avl_clk);
    while (idx < n_beats) begin
      dma_valid <= 1'b1;
      dma_data <= beat_list[idx];
      dma_xfer_last <= (idx == n_beats - 1);
      @(negedge avl_clk);
      while (!dma_ready_out) begin
        @(negedge avl_clk);
      end
      // beat is taken on this edge
      @(posedge avl_clk);
      idx++;
    end
    dma_valid <= 1'b0;
    dma_xfer_last <= 1'b0;
  endtask

  task automatic close_test(input string name, input int errors_before);
    test_count++;
    if (error_count != errors_before) begin
      fail_count++;
    end
    $display("test %s: %0d writes, %0d errors, %s", name, wr_count,
             error_count - errors_before, (error_count == errors_before) ? "ok" : "error");
  endtask

  task automatic run_transfer(input string name, input int n_beats, input int mode,
                              input int stall);
    int errors_before;
    int low_before;
    int i;
    avl_write_t last;
    errors_before = error_count;
    low_before = ready_low_count;
    @(negedge avl_clk);
    beat_list.delete();
    for (i = 0; i < n_beats; i++) begin
      beat_list.push_back($random(seed));
    end
    n_words = (n_beats + LANES - 1) / LANES;
    wr_count = 0;
    ready_mode = mode;
    stall_end = cycle_count + stall;
    @(posedge avl_clk);
    dma_xfer_req <= 1'b1;
    // the master clears avl_xfer_req one edge after the request rises
    repeat (2) @(negedge avl_clk);
    if (avl_xfer_req !== 1'b0) begin
      report_mismatch("avl_xfer_req", $sformatf("at the start of %s", name),
                      AVL_DW'(avl_xfer_req), AVL_DW'(1'b0));
    end
    drive_beats(n_beats);
    while (!avl_xfer_req) begin
      @(negedge avl_clk);
    end
    if (wr_count != n_words) begin
      error_count++;
      $display("avl_xfer_req rose after %0d writes, expected %0d", wr_count, n_words);
    end
    last = expected_word(n_words - 1);
    if (avl_last_address !== last.address) begin
      report_mismatch("avl_last_address", $sformatf("in %s", name),
                      AVL_DW'(avl_last_address), AVL_DW'(last.address));
    end
    if (avl_last_byteenable !== last.byteenable) begin
      report_mismatch("avl_last_byteenable", $sformatf("in %s", name),
                      AVL_DW'(avl_last_byteenable), AVL_DW'(last.byteenable));
    end
    if (stall > 0 && ready_low_count == low_before) begin
      error_count++;
      $display("dma_ready_out stayed high through the memory stall");
    end
    @(posedge avl_clk);
    dma_xfer_req <= 1'b0;
    repeat (3) @(posedge avl_clk);
    close_test(name, errors_before);
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin
    avl_reset <= 1'b1;
    dma_data <= '0;
    dma_valid <= 1'b0;
    dma_xfer_req <= 1'b0;
    dma_xfer_last <= 1'b0;
    repeat (8) @(posedge avl_clk);
    avl_reset <= 1'b0;
    @(negedge avl_clk);
    if (avl_write !== 1'b0) begin
      report_mismatch("avl_write", "after reset", AVL_DW'(avl_write), AVL_DW'(1'b0));
    end
    if (avl_xfer_req !== 1'b0) begin
      report_mismatch("avl_xfer_req", "after reset", AVL_DW'(avl_xfer_req), AVL_DW'(1'b0));
    end
    if (dma_ready_out !== 1'b0) begin
      report_mismatch("dma_ready_out", "after reset", AVL_DW'(dma_ready_out), AVL_DW'(1'b0));
    end
    close_test("reset_state", 0);

    run_transfer("full_word", 32, 0, 0);
    run_transfer("partial_m1", 9, 0, 0);
    run_transfer("partial_m2", 14, 0, 0);
    run_transfer("partial_m3", 7, 0, 0);
    run_transfer("back_pressure", 120, 1, 100);
    run_transfer("address_wrap", 240, 0, 0);
    // in back to back sessions the second restarts at the base address
    run_transfer("sequence_first", 22, 1, 0);
    run_transfer("sequence_second", 17, 1, 0);

    $display("tests %0d, failed tests %0d, errors %0d", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge avl_clk);
    $display("watchdog expired after %0d cycles before all tests completed", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
src/dacfifo_pkg.sv
src/dma_beat_packer.sv
src/word_buffer.sv
src/avl_write_master.sv
src/avl_dacfifo_wr.sv
verification/tb_avl_dacfifo_wr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DAC FIFO write path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_avl_dacfifo_wr \
  -f project.f

sim_status=0
./obj_dir/Vtb_avl_dacfifo_wr > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "simulation finished without failures"
